//--- verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [63:0] mtime_t;

  // One-hot, bit 0 bram, bit 1 print, bit 2 clint
  typedef logic [2:0] slave_sel_t;

  typedef struct packed {
    logic valid;
    logic instr;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic ready;
  } mem_rsp_t;

  localparam slave_sel_t sel_bram = 3'b001;
  localparam slave_sel_t sel_print = 3'b010;
  localparam slave_sel_t sel_clint = 3'b100;

  // Memory map
  localparam word_t bram_base = 32'h0000_0000;
  localparam word_t print_base = 32'h0100_0000;
  localparam word_t print_top = 32'h0100_0004;
  localparam word_t clint_base = 32'h0200_0000;
  localparam word_t clint_top = 32'h0200_C000;

  // CLINT register offsets, high words sit 4 bytes above
  localparam word_t msip_off = 32'h0000_0000;
  localparam word_t mtimecmp_off = 32'h0000_4000;
  localparam word_t mtime_off = 32'h0000_BFF8;

endpackage

`default_nettype wire

//--- verilog/port_decoder.sv
`default_nettype none

module port_decoder #(
  parameter int unsigned bram_words = 1024,
  parameter soc_pkg::word_t host_addr = 32'h0000_1000
) (
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::slave_sel_t sel_o,
  output soc_pkg::mem_req_t req_o
);
  import soc_pkg::*;

  localparam word_t bram_top = word_t'(bram_words * 4);

  word_t base;

  // Unsigned window test, also correct for a base of 0
  function automatic logic in_region(word_t addr, word_t lo, word_t hi);
    return (addr - lo) < (hi - lo);
  endfunction

  always_comb begin
    sel_o = '0;
    base = '0;
    if (in_region(req_i.addr, clint_base, clint_top)) begin
      sel_o = sel_clint;
      base = clint_base;
    end else if (in_region(req_i.addr, print_base, print_top)) begin
      sel_o = sel_print;
      base = print_base;
    end else if (in_region(req_i.addr, bram_base, bram_top)) begin
      sel_o = sel_bram;
      base = bram_base;
    end else if (req_i.addr == host_addr) begin
      sel_o = sel_bram;
      base = '0;
    end

    req_o = req_i;
    req_o.addr = req_i.addr - base;

    if (!req_i.valid) begin
      sel_o = '0;
      req_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/bus_crossbar.sv
`default_nettype none

module bus_crossbar (
  input  logic clk,
  input  logic rst,
  input  soc_pkg::slave_sel_t isel_i,
  input  soc_pkg::slave_sel_t dsel_i,
  input  soc_pkg::mem_req_t ireq_i,
  input  soc_pkg::mem_req_t dreq_i,
  output soc_pkg::mem_req_t bram_req_o,
  output soc_pkg::mem_req_t print_req_o,
  output soc_pkg::mem_req_t clint_req_o,
  input  soc_pkg::mem_rsp_t bram_rsp_i,
  input  soc_pkg::mem_rsp_t print_rsp_i,
  input  soc_pkg::mem_rsp_t clint_rsp_i,
  output soc_pkg::mem_rsp_t irsp_o,
  output soc_pkg::mem_rsp_t drsp_o
);
  import soc_pkg::*;

  typedef struct packed {
    slave_sel_t i;
    slave_sel_t d;
  } owner_t;

  owner_t own_q;
  owner_t own_n;
  slave_sel_t igrant;
  slave_sel_t dgrant;
  slave_sel_t slv_ready;
  mem_rsp_t slv_rsp [3];
  mem_req_t slv_req [3];

  assign slv_rsp[0] = bram_rsp_i;
  assign slv_rsp[1] = print_rsp_i;
  assign slv_rsp[2] = clint_rsp_i;

  assign slv_ready = {clint_rsp_i.ready, print_rsp_i.ready, bram_rsp_i.ready};

  // Walk down so that bram has the last word
  always_comb begin
    irsp_o = '0;
    drsp_o = '0;
    for (int k = 2; k >= 0; k--) begin
      if (own_q.i[k] && slv_rsp[k].ready) begin
        irsp_o = slv_rsp[k];
      end
      if (own_q.d[k] && slv_rsp[k].ready) begin
        drsp_o = slv_rsp[k];
      end
    end
  end

  // A port that sees ready this cycle is done and must not reissue
  always_comb begin
    dgrant = drsp_o.ready ? '0 : dsel_i;
    igrant = irsp_o.ready ? '0 : (isel_i & ~dgrant);
    for (int k = 0; k < 3; k++) begin
      slv_req[k] = dgrant[k] ? dreq_i : ireq_i;
      slv_req[k].valid = dgrant[k] | igrant[k];
    end
  end

  assign bram_req_o = slv_req[0];
  assign print_req_o = slv_req[1];
  assign clint_req_o = slv_req[2];

  always_comb begin
    own_n.i = (own_q.i & ~slv_ready) | igrant;
    own_n.d = (own_q.d & ~slv_ready) | dgrant;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      own_q <= '0;
    end else begin
      own_q <= own_n;
    end
  end

endmodule

`default_nettype wire

//--- verilog/bram.sv
`default_nettype none

module bram #(
  parameter int unsigned bram_words = 1024
) (
  input  logic clk,
  input  logic rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o
);
  import soc_pkg::*;

  localparam int unsigned aw = (bram_words > 1) ? $clog2(bram_words) : 1;

  typedef logic [aw-1:0] idx_t;

  word_t mem [bram_words];
  idx_t idx;
  word_t rdata_q;
  logic ready_q;

  // Word index wraps at the memory depth
  assign idx = idx_t'((req_i.addr >> 2) % bram_words);

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
    end
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

//--- verilog/print_port.sv
`default_nettype none

module print_port (
  input  logic clk,
  input  logic rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic char_valid_o,
  output logic [7:0] char_o
);
  import soc_pkg::*;

  logic ready_q;
  logic emit;

  assign emit = req_i.valid && req_i.wstrb[0] && (req_i.addr == '0);

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
      char_valid_o <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
      char_valid_o <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      char_o <= req_i.wdata[7:0];
    end
  end

  // Reads always see zero
  assign rsp_o = '{rdata: '0, ready: ready_q};

endmodule

`default_nettype wire

//--- verilog/clint.sv
`default_nettype none

module clint (
  input  logic clk,
  input  logic rst,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic msip_o,
  output logic mtip_o,
  output soc_pkg::mtime_t mtime_o
);
  import soc_pkg::*;

  mtime_t mtime_q;
  mtime_t mtime_n;
  mtime_t mtimecmp_q;
  logic msip_q;
  logic ready_q;
  logic wr;
  word_t rdata_n;
  word_t rdata_q;

  assign wr = req_i.valid && (req_i.wstrb != '0);

  always_comb begin
    case (req_i.addr)
      msip_off: rdata_n = {31'b0, msip_q};
      mtimecmp_off: rdata_n = mtimecmp_q[31:0];
      mtimecmp_off + 32'd4: rdata_n = mtimecmp_q[63:32];
      mtime_off: rdata_n = mtime_q[31:0];
      mtime_off + 32'd4: rdata_n = mtime_q[63:32];
      default: rdata_n = '0;
    endcase
  end

  // Software write takes the place of the increment
  always_comb begin
    mtime_n = mtime_q + 64'd1;
    if (wr && req_i.addr == mtime_off) begin
      mtime_n = {mtime_q[63:32], req_i.wdata};
    end else if (wr && req_i.addr == mtime_off + 32'd4) begin
      mtime_n = {req_i.wdata, mtime_q[31:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_q <= '0;
      mtimecmp_q <= '1;
      msip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      mtime_q <= mtime_n;
      ready_q <= req_i.valid;
      if (wr && req_i.addr == msip_off) begin
        msip_q <= req_i.wdata[0];
      end
      if (wr && req_i.addr == mtimecmp_off) begin
        mtimecmp_q[31:0] <= req_i.wdata;
      end
      if (wr && req_i.addr == mtimecmp_off + 32'd4) begin
        mtimecmp_q[63:32] <= req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      rdata_q <= rdata_n;
    end
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready_q};
  assign msip_o = msip_q;
  assign mtip_o = (mtime_q >= mtimecmp_q);
  assign mtime_o = mtime_q;

endmodule

`default_nettype wire

//--- verilog/soc_bus.sv
`default_nettype none

module soc_bus #(
  parameter int unsigned bram_words = 1024,
  parameter soc_pkg::word_t host_addr = 32'h0000_1000
) (
  input  logic clk,
  input  logic rst,
  input  soc_pkg::mem_req_t ireq_i,
  output soc_pkg::mem_rsp_t irsp_o,
  input  soc_pkg::mem_req_t dreq_i,
  output soc_pkg::mem_rsp_t drsp_o,
  output logic char_valid_o,
  output logic [7:0] char_o,
  output logic msip_o,
  output logic mtip_o,
  output soc_pkg::mtime_t mtime_o
);
  import soc_pkg::*;

  slave_sel_t isel;
  slave_sel_t dsel;
  mem_req_t ireq_loc;
  mem_req_t dreq_loc;
  mem_req_t bram_req;
  mem_req_t print_req;
  mem_req_t clint_req;
  mem_rsp_t bram_rsp;
  mem_rsp_t print_rsp;
  mem_rsp_t clint_rsp;

  port_decoder #(
    .bram_words(bram_words),
    .host_addr(host_addr)
  ) i_decode (
    .req_i(ireq_i),
    .sel_o(isel),
    .req_o(ireq_loc)
  );

  port_decoder #(
    .bram_words(bram_words),
    .host_addr(host_addr)
  ) d_decode (
    .req_i(dreq_i),
    .sel_o(dsel),
    .req_o(dreq_loc)
  );

  bus_crossbar i_crossbar (
    .clk(clk),
    .rst(rst),
    .isel_i(isel),
    .dsel_i(dsel),
    .ireq_i(ireq_loc),
    .dreq_i(dreq_loc),
    .bram_req_o(bram_req),
    .print_req_o(print_req),
    .clint_req_o(clint_req),
    .bram_rsp_i(bram_rsp),
    .print_rsp_i(print_rsp),
    .clint_rsp_i(clint_rsp),
    .irsp_o(irsp_o),
    .drsp_o(drsp_o)
  );

  bram #(
    .bram_words(bram_words)
  ) i_bram (
    .clk(clk),
    .rst(rst),
    .req_i(bram_req),
    .rsp_o(bram_rsp)
  );

  print_port i_print (
    .clk(clk),
    .rst(rst),
    .req_i(print_req),
    .rsp_o(print_rsp),
    .char_valid_o(char_valid_o),
    .char_o(char_o)
  );

  clint i_clint (
    .clk(clk),
    .rst(rst),
    .req_i(clint_req),
    .rsp_o(clint_rsp),
    .msip_o(msip_o),
    .mtip_o(mtip_o),
    .mtime_o(mtime_o)
  );

endmodule

`default_nettype wire

//--- sim/soc_bus_properties.sv
`default_nettype none

module soc_bus_properties (
  input logic clk,
  input logic rst,
  input soc_pkg::slave_sel_t igrant_i,
  input soc_pkg::slave_sel_t dgrant_i,
  input logic iready_i,
  input logic dready_i,
  input logic [5:0] own_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Sampled mid-cycle once grants and responses settle
  iready_after_grant: assert property (@(negedge clk) disable iff (!rst)
    iready_i |-> $past(igrant_i != '0))
    else $error("instruction ready without a grant in the cycle before");

  dready_after_grant: assert property (@(negedge clk) disable iff (!rst)
    dready_i |-> $past(dgrant_i != '0))
    else $error("data ready without a grant in the cycle before");

  // Owner flags of the instruction port sit in the upper half
  owners_disjoint: assert property (@(negedge clk) disable iff (!rst)
    (own_i[5:3] & own_i[2:0]) == '0)
    else $error("one slave owned by both ports");

endmodule

bind bus_crossbar soc_bus_properties i_props (
  .clk(clk),
  .rst(rst),
  .igrant_i(igrant),
  .dgrant_i(dgrant),
  .iready_i(irsp_o.ready),
  .dready_i(drsp_o.ready),
  .own_i(own_q)
);

`default_nettype wire

//--- sim/soc_bus_tb.sv
`default_nettype none

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_pkg::*;

  localparam int unsigned bram_words = 1024;
  localparam word_t host_addr = 32'h0000_1000;
  // About ten times the cycles the whole sequence needs
  localparam int max_cycles = 2000;

  logic clk = 1'b0;
  logic rst;
  mem_req_t ireq;
  mem_req_t dreq;
  mem_rsp_t irsp;
  mem_rsp_t drsp;
  logic char_valid;
  logic [7:0] char_byte;
  logic msip;
  logic mtip;
  mtime_t mtime;

  int errors = 0;
  int checks = 0;
  integer seed = 32'h5cc3_94ec;

  // Reference model state
  word_t bram_m [bram_words];
  mtime_t cmp_m = '1;
  logic msip_m = 1'b0;
  mtime_t cycle_cnt = '0;
  int char_cnt = 0;
  logic [7:0] exp_char = '0;

  // One request in flight per port
  logic d_busy = 1'b0;
  word_t d_addr;
  word_t d_wdata;
  strb_t d_wstrb;
  mtime_t d_issue;
  logic i_busy = 1'b0;
  word_t i_addr;
  mtime_t i_issue;

  soc_bus #(
    .bram_words(bram_words),
    .host_addr(host_addr)
  ) i_soc_bus (
    .clk(clk),
    .rst(rst),
    .ireq_i(ireq),
    .irsp_o(irsp),
    .dreq_i(dreq),
    .drsp_o(drsp),
    .char_valid_o(char_valid),
    .char_o(char_byte),
    .msip_o(msip),
    .mtip_o(mtip),
    .mtime_o(mtime)
  );

  always #4 clk = ~clk;

  // Timer model counts every edge out of reset
  always @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

  function automatic int word_index(input word_t addr);
    return int'((addr >> 2) % bram_words);
  endfunction

  function automatic logic in_clint(input word_t addr);
    return addr >= clint_base && addr < clint_top;
  endfunction

  function automatic logic in_print(input word_t addr);
    return addr >= print_base && addr < print_top;
  endfunction

  // Expected read data; anything outside clint and print lands in bram
  function automatic word_t ref_rdata(input word_t addr);
    word_t off;
    off = addr - clint_base;
    if (in_print(addr)) begin
      return '0;
    end
    if (!in_clint(addr)) begin
      return bram_m[word_index(addr)];
    end
    case (off)
      msip_off: return word_t'(msip_m);
      mtimecmp_off: return cmp_m[31:0];
      mtimecmp_off + 32'd4: return cmp_m[63:32];
      default: return '0;
    endcase
  endfunction

  task automatic apply_write(input word_t addr, input word_t wdata, input strb_t wstrb);
    word_t off;
    off = addr - clint_base;
    if (in_clint(addr)) begin
      if (off == msip_off) begin
        msip_m = wdata[0];
      end else if (off == mtimecmp_off) begin
        cmp_m[31:0] = wdata;
      end else if (off == mtimecmp_off + 32'd4) begin
        cmp_m[63:32] = wdata;
      end
    end else if (!in_print(addr)) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          bram_m[word_index(addr)][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %0t ns %s expected %08h actual %08h", $time, name, expected, actual);
    end
  endtask

  task automatic complete(input string name, input word_t rdata, input word_t addr,
                          input word_t wdata, input strb_t wstrb, input mtime_t issued);
    word_t lo;
    word_t hi;
    lo = issued[31:0];
    hi = cycle_cnt[31:0];
    if (wstrb != '0) begin
      apply_write(addr, wdata, wstrb);
    end else if (addr == clint_base + mtime_off) begin
      // Sampled somewhere between issue and completion
      checks++;
      if (rdata < lo || rdata > hi) begin
        errors++;
        $display("ERROR %0t ns %s mtime read %0d is outside %0d to %0d",
                 $time, name, rdata, lo, hi);
      end
    end else begin
      check_value(name, rdata, ref_rdata(addr));
    end
  endtask

  task automatic data_access(input word_t addr, input word_t wdata, input strb_t wstrb,
                             output int lat);
    @(posedge clk);
    #1;
    dreq = '{valid: 1'b1, instr: 1'b0, addr: addr, wdata: wdata, wstrb: wstrb};
    d_addr = addr;
    d_wdata = wdata;
    d_wstrb = wstrb;
    d_issue = cycle_cnt;
    d_busy = 1'b1;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!drsp.ready);
    @(posedge clk);
    #1;
    dreq = '0;
  endtask

  task automatic instr_fetch(input word_t addr, output int lat);
    @(posedge clk);
    #1;
    ireq = '{valid: 1'b1, instr: 1'b1, addr: addr, wdata: '0, wstrb: '0};
    i_addr = addr;
    i_issue = cycle_cnt;
    i_busy = 1'b1;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!irsp.ready);
    @(posedge clk);
    #1;
    ireq = '0;
  endtask

  // Compare every response mid-cycle with the data port first
  initial begin
    forever begin
      @(negedge clk);
      if (drsp.ready) begin
        if (d_busy) begin
          d_busy = 1'b0;
          complete("drsp_o.rdata", drsp.rdata, d_addr, d_wdata, d_wstrb, d_issue);
        end else begin
          errors++;
          $display("Data port answered with no request outstanding at %0t ns", $time);
        end
      end
      if (irsp.ready) begin
        if (i_busy) begin
          i_busy = 1'b0;
          complete("irsp_o.rdata", irsp.rdata, i_addr, '0, '0, i_issue);
        end else begin
          errors++;
          $display("Instruction port answered with no request outstanding at %0t ns", $time);
        end
      end
      if (char_valid) begin
        char_cnt++;
        check_value("char_o", word_t'(char_byte), word_t'(exp_char));
      end
    end
  end

  initial begin
    word_t addrs [8];
    word_t w;
    strb_t s;
    word_t cmp_lo;
    int lat;
    int ilat;
    rst = 1'b0;
    ireq = '0;
    dreq = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;

    // Full-word fill and then a partial overwrite of each word
    for (int n = 0; n < 8; n++) begin
      w = $random(seed);
      addrs[n] = {22'b0, w[7:0], 2'b00};
      data_access(addrs[n], $random(seed), 4'hf, lat);
      w = $random(seed);
      s = w[3:0];
      if (s == '0) begin
        s = 4'b0101;
      end
      data_access(addrs[n], $random(seed), s, lat);
    end
    for (int n = 0; n < 8; n++) begin
      data_access(addrs[n], '0, '0, lat);
      check_value("data read latency", word_t'(lat), 32'd1);
    end

    instr_fetch(addrs[0], ilat);
    check_value("fetch latency", word_t'(ilat), 32'd1);

    // Data wins when both ports want bram
    w = $random(seed);
    fork
      data_access(addrs[1], w, 4'hf, lat);
      instr_fetch(addrs[1], ilat);
    join
    check_value("contended data latency", word_t'(lat), 32'd1);
    check_value("contended fetch latency", word_t'(ilat), 32'd2);

    w = $random(seed);
    exp_char = w[7:0];
    char_cnt = 0;
    fork
      data_access(print_base, w, 4'h1, lat);
      instr_fetch(addrs[2], ilat);
    join
    check_value("parallel fetch latency", word_t'(ilat), 32'd1);
    repeat (3) @(negedge clk);
    check_value("char_valid_o pulses", word_t'(char_cnt), 32'd1);

    data_access(clint_base + mtime_off, '0, '0, lat);
    @(negedge clk);
    check_value("mtime_o", mtime[31:0], cycle_cnt[31:0]);
    check_value("mtime_o high word", mtime[63:32], cycle_cnt[63:32]);
    data_access(clint_base + mtimecmp_off + 32'd4, '0, 4'hf, lat);
    cmp_lo = cycle_cnt[31:0] + 32'd20;
    data_access(clint_base + mtimecmp_off, cmp_lo, 4'hf, lat);
    data_access(clint_base + mtimecmp_off, '0, '0, lat);
    // Walk mtime across the compare value
    repeat (24) begin
      @(negedge clk);
      check_value("mtip_o", word_t'(mtip), word_t'(cycle_cnt >= cmp_m));
    end
    check_value("mtip_o after crossing", word_t'(mtip), 32'd1);
    data_access(clint_base + msip_off, 32'd1, 4'hf, lat);
    @(negedge clk);
    check_value("msip_o", word_t'(msip), 32'd1);
    data_access(clint_base + msip_off, '0, '0, lat);

    w = $random(seed);
    data_access(host_addr, w, 4'hf, lat);
    data_access(word_t'(((host_addr >> 2) % bram_words) << 2), '0, '0, lat);

    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("Timeout: simulation did not finish within %0d clock cycles", max_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/soc_pkg.sv
verilog/port_decoder.sv
verilog/bus_crossbar.sv
verilog/bram.sv
verilog/print_port.sv
verilog/clint.sv
verilog/soc_bus.sv
sim/soc_bus_properties.sv
sim/soc_bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module soc_bus_tb -f sim.f --Mdir obj_dir -o soc_bus_sim

./obj_dir/soc_bus_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
